// File: exec_core.f
+incdir+hdl
hdl/exec_pkg.sv
hdl/exec_arith.sv
hdl/exec_bits.sv
hdl/exec_alu.sv
hdl/exec_unit.sv
hdl/exec_core.sv
sim/exec_clock_gen.sv
sim/exec_tb.sv

// File: hdl/exec_alu.sv
// --------------------
// ALU wrapper. Registers the incoming operation, feeds
// both units in parallel and carries the destination
// alongside. The final value is picked by the opcode that
// the execution unit has delayed to the last stage.
// --------------------

`timescale 1ns/1ps
`include "exec_cfg.svh"

module exec_alu import exec_pkg::*; (
    input logic clock,
    input logic rst_n,
    input opcode_t opcode,
    input reg_addr_t dest,
    input data_t operand_a,
    input data_t operand_b,
    input opcode_t select_op,
    output data_t alu_data,
    output reg_addr_t alu_dest
);

    opcode_t op_q;
    data_t a_q;
    data_t b_q;
    data_t arith_value;
    data_t bits_value;
    reg_addr_t dest_dly [`EXEC_ALU_STAGES];

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            op_q <= NOP;
            a_q <= '0;
            b_q <= '0;
            for (int i = 0; i < `EXEC_ALU_STAGES; i++) begin
                dest_dly[i] <= '0;
            end
        end else begin
            op_q <= opcode;
            a_q <= operand_a;
            b_q <= operand_b;
            dest_dly[0] <= dest;
            for (int i = 1; i < `EXEC_ALU_STAGES; i++) begin
                dest_dly[i] <= dest_dly[i-1];
            end
        end
    end

    exec_arith i_arith (
        .clock(clock),
        .rst_n(rst_n),
        .opcode(op_q),
        .operand_a(a_q),
        .operand_b(b_q),
        .value(arith_value)
    );

    exec_bits i_bits (
        .clock(clock),
        .rst_n(rst_n),
        .opcode(op_q),
        .operand_a(a_q),
        .operand_b(b_q),
        .value(bits_value)
    );

    always_comb begin
        case (select_op)
            ADD, SUB, MUL, ABS, SATP, SATN: alu_data = arith_value;
            default: alu_data = bits_value;
        endcase
    end

    assign alu_dest = dest_dly[`EXEC_ALU_STAGES-1];

endmodule

// File: hdl/exec_arith.sv
// --------------------
// Arithmetic half of the ALU.
// Two register stages: the first holds every candidate
// result, the second keeps the one the opcode asks for.
// Opcodes it does not own produce zero.
// --------------------

`timescale 1ns/1ps
`include "exec_cfg.svh"

module exec_arith import exec_pkg::*; (
    input logic clock,
    input logic rst_n,
    input opcode_t opcode,
    input data_t operand_a,
    input data_t operand_b,
    output data_t value
);

    logic signed [2*`EXEC_DATA_WIDTH-1:0] product_full;
    logic a_gt_b;
    logic a_lt_b;

    opcode_t op_q;
    data_t sum_q;
    data_t diff_q;
    data_t prod_q;
    data_t abs_q;
    data_t satp_q;
    data_t satn_q;

    assign product_full = $signed(operand_a) * $signed(operand_b);
    assign a_gt_b = $signed(operand_a) > $signed(operand_b);
    assign a_lt_b = $signed(operand_a) < $signed(operand_b);

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            op_q <= NOP;
            sum_q <= '0;
            diff_q <= '0;
            prod_q <= '0;
            abs_q <= '0;
            satp_q <= '0;
            satn_q <= '0;
        end else begin
            op_q <= opcode;
            sum_q <= operand_a + operand_b;
            diff_q <= operand_a - operand_b;
            // Only the low word survives, so large products wrap
            prod_q <= product_full[`EXEC_DATA_WIDTH-1:0];
            abs_q <= operand_a[`EXEC_DATA_WIDTH-1] ? -operand_a : operand_a;
            // b acts as the upper bound for SATP and the lower bound for SATN
            satp_q <= a_gt_b ? operand_b : operand_a;
            satn_q <= a_lt_b ? operand_b : operand_a;
        end
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            value <= '0;
        end else begin
            case (op_q)
                ADD: value <= sum_q;
                SUB: value <= diff_q;
                MUL: value <= prod_q;
                ABS: value <= abs_q;
                SATP: value <= satp_q;
                SATN: value <= satn_q;
                default: value <= '0;
            endcase
        end
    end

endmodule

// File: hdl/exec_bits.sv
// --------------------
// Logic and compare half of the ALU.
// Same two-stage shape as the arithmetic unit. Compares
// are signed and return their truth in bit 0 only.
// --------------------

`timescale 1ns/1ps
`include "exec_cfg.svh"

module exec_bits import exec_pkg::*; (
    input logic clock,
    input logic rst_n,
    input opcode_t opcode,
    input data_t operand_a,
    input data_t operand_b,
    output data_t value
);

    localparam int SEL_WIDTH = $clog2(`EXEC_DATA_WIDTH);

    function automatic data_t popcount(input data_t word);
        data_t count;
        count = '0;
        for (int i = 0; i < `EXEC_DATA_WIDTH; i++) begin
            count = count + data_t'(word[i]);
        end
        return count;
    endfunction

    opcode_t op_q;
    data_t and_q;
    data_t or_q;
    data_t xor_q;
    data_t popcnt_q;
    logic bsel_q;
    logic gt_q;
    logic eq_q;

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            op_q <= NOP;
            and_q <= '0;
            or_q <= '0;
            xor_q <= '0;
            popcnt_q <= '0;
            bsel_q <= 1'b0;
            gt_q <= 1'b0;
            eq_q <= 1'b0;
        end else begin
            op_q <= opcode;
            and_q <= operand_a & operand_b;
            or_q <= operand_a | operand_b;
            xor_q <= operand_a ^ operand_b;
            popcnt_q <= popcount(operand_a);
            bsel_q <= operand_a[operand_b[SEL_WIDTH-1:0]];
            // BLE and BNE are taken as the inverse of these two
            gt_q <= $signed(operand_a) > $signed(operand_b);
            eq_q <= operand_a == operand_b;
        end
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            value <= '0;
        end else begin
            case (op_q)
                LAND: value <= and_q;
                LOR: value <= or_q;
                LXOR: value <= xor_q;
                POPCNT: value <= popcnt_q;
                BSEL: value <= data_t'(bsel_q);
                BGT: value <= data_t'(gt_q);
                BLE: value <= data_t'(!gt_q);
                BEQ: value <= data_t'(eq_q);
                BNE: value <= data_t'(!eq_q);
                default: value <= '0;
            endcase
        end
    end

endmodule

// File: hdl/exec_cfg.svh
// --------------------
// Width and latency settings for the execution stage.
// Include this header in any file that sizes vectors or
// depends on the ALU pipeline depth.
// --------------------

`ifndef EXEC_CFG_SVH
`define EXEC_CFG_SVH

// Operand and result word width
`define EXEC_DATA_WIDTH 32

// Opcode field width, wide enough for all sixteen operations
`define EXEC_OPCODE_WIDTH 4

// Destination register address width
`define EXEC_REG_ADDR_WIDTH 4

// Cycles from an accepted issue to stable ALU output.
// One operand register plus two unit stages, and also
// the depth of the opcode delay line in the execution unit
`define EXEC_ALU_STAGES 3

`endif

// File: hdl/exec_core.sv
// --------------------
// Top level of the execution stage.
// Takes at most one instruction per cycle on the issue
// port and returns results in order on the writeback
// port four cycles later. Neither side can stall.
// --------------------

`timescale 1ns/1ps

module exec_core import exec_pkg::*; (
    input logic clock,
    input logic rst_n,
    input issue_t issue,
    output wb_t wb
);

    issue_t issue_w;
    wb_t wb_w;

    assign issue_w = issue;
    assign wb = wb_w;

    exec_unit i_unit (
        .clock(clock),
        .rst_n(rst_n),
        .issue(issue_w),
        .wb(wb_w)
    );

endmodule

// File: hdl/exec_pkg.sv
// --------------------
// Shared types for the execution stage.
// Holds the opcode encoding, the word typedefs and the
// issue and writeback records. Modules import it whole.
// --------------------

`include "exec_cfg.svh"

package exec_pkg;

    typedef logic [`EXEC_DATA_WIDTH-1:0] data_t;
    typedef logic [`EXEC_REG_ADDR_WIDTH-1:0] reg_addr_t;

    // Order fixes the encoding, NOP must stay at zero
    typedef enum logic [`EXEC_OPCODE_WIDTH-1:0] {
        NOP,
        ADD,
        SUB,
        MUL,
        ABS,
        SATP,
        SATN,
        LAND,
        LOR,
        LXOR,
        POPCNT,
        BSEL,
        BGT,
        BLE,
        BEQ,
        BNE
    } opcode_t;

    // One instruction as delivered by the issue port
    typedef struct packed {
        logic valid;
        opcode_t opcode;
        reg_addr_t dest;
        data_t operand_a;
        data_t operand_b;
    } issue_t;

    // One result headed for the register file
    typedef struct packed {
        logic valid;
        reg_addr_t dest;
        data_t data;
    } wb_t;

endpackage

// File: hdl/exec_unit.sv
// --------------------
// Execution unit. Runs each issued instruction through
// the ALU and shapes the result into a writeback record
// one cycle after the ALU output settles. Compares are
// widened to a full mask and NOP yields no record.
// --------------------

`timescale 1ns/1ps
`include "exec_cfg.svh"

module exec_unit import exec_pkg::*; (
    input logic clock,
    input logic rst_n,
    input issue_t issue,
    output wb_t wb
);

    opcode_t issue_op;
    opcode_t op_dly [`EXEC_ALU_STAGES];
    data_t alu_data;
    reg_addr_t alu_dest;

    // An empty issue slot travels down the pipe as a bubble
    assign issue_op = issue.valid ? issue.opcode : NOP;

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `EXEC_ALU_STAGES; i++) begin
                op_dly[i] <= NOP;
            end
        end else begin
            op_dly[0] <= issue_op;
            for (int i = 1; i < `EXEC_ALU_STAGES; i++) begin
                op_dly[i] <= op_dly[i-1];
            end
        end
    end

    exec_alu i_alu (
        .clock(clock),
        .rst_n(rst_n),
        .opcode(issue_op),
        .dest(issue.dest),
        .operand_a(issue.operand_a),
        .operand_b(issue.operand_b),
        .select_op(op_dly[`EXEC_ALU_STAGES-1]),
        .alu_data(alu_data),
        .alu_dest(alu_dest)
    );

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            wb <= '0;
        end else begin
            case (op_dly[`EXEC_ALU_STAGES-1])
                NOP: begin
                    wb <= '0;
                end
                BGT, BLE, BEQ, BNE: begin
                    wb.valid <= 1'b1;
                    wb.dest <= alu_dest;
                    wb.data <= alu_data[0] ? '1 : '0;
                end
                default: begin
                    wb.valid <= 1'b1;
                    wb.dest <= alu_dest;
                    wb.data <= alu_data;
                end
            endcase
        end
    end

endmodule

// File: run_sim.sh
#!/bin/sh
# Builds the execution stage testbench with Verilator and runs it.
# Exits non-zero on a build error, a simulator error or a failing test.

cd "$(dirname "$0")" || exit 1

LOG=sim_run.log

verilator --binary --timing --timescale 1ns/1ps --top-module exec_tb \
    -f exec_core.f -Mdir obj_dir -o exec_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/exec_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Finished with errors" "$LOG"; then
    exit 1
fi

exit 0

// File: sim/exec_clock_gen.sv
// --------------------
// Clock and reset source for the execution stage testbench.
// Produces a 100 ns clock and holds rst_n low for the
// first four rising edges.
// --------------------

`timescale 1ns/1ps

module exec_clock_gen (
    output logic clock,
    output logic rst_n
);

    localparam int HALF_PERIOD = 50;
    localparam int RESET_CYCLES = 4;

    initial begin
        clock = 1'b0;
        forever begin
            #(HALF_PERIOD);
            clock = ~clock;
        end
    end

    // Release lands just after an edge, like all other stimulus
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) begin
            @(posedge clock);
        end
        #1;
        rst_n = 1'b1;
    end

endmodule

// File: sim/exec_stim.txt
# Columns: opcode dest operand_a operand_b expected_data test_name, all numbers in hex
# Opcodes: 0 NOP 1 ADD 2 SUB 3 MUL 4 ABS 5 SATP 6 SATN 7 LAND 8 LOR 9 LXOR A POPCNT B BSEL C BGT D BLE E BEQ F BNE
1 1 00000005 00000007 0000000C add_small
1 2 7FFFFFFF 00000001 80000000 add_overflow
2 4 0000000A 00000003 00000007 sub_small
2 5 00000003 0000000A FFFFFFF9 sub_negative
2 6 80000000 00000001 7FFFFFFF sub_wrap
3 7 00000006 00000007 0000002A mul_small
3 8 FFFFFFFD 00000004 FFFFFFF4 mul_negative
3 9 00010000 00010000 00000000 mul_wrap
3 A FFFFFFFF FFFFFFFF 00000001 mul_neg_neg
4 B FFFFFFF6 00000000 0000000A abs_negative
4 D 80000000 00000000 80000000 abs_min
5 E 00000064 00000032 00000032 satp_clamp
5 F FFFFFF9C 00000032 FFFFFF9C satp_pass
6 1 FFFFFF9C FFFFFFCE FFFFFFCE satn_clamp
6 2 00000010 FFFFFFCE 00000010 satn_pass
7 3 F0F0F0F0 FF00FF00 F000F000 land
8 4 F0F0F0F0 0F0F0000 FFFFF0F0 lor
9 5 AAAA5555 FFFF0000 55555555 lxor
A 7 FFFFFFFF 00000000 00000020 popcnt_all
A 8 8000000F 12345678 00000005 popcnt_mixed
B 9 00000010 00000004 00000001 bsel_set
B A 00000010 00000003 00000000 bsel_clear
B B 80000000 0000003F 00000001 bsel_msb
C C 00000005 00000003 FFFFFFFF bgt_true
C D FFFFFFFF 00000001 00000000 bgt_signed
D E 80000000 7FFFFFFF FFFFFFFF ble_signed
D F 00000004 00000004 FFFFFFFF ble_equal
D 1 00000005 00000004 00000000 ble_false
E 2 12345678 12345678 FFFFFFFF beq_true
E 3 12345678 12345679 00000000 beq_false
F 4 00000000 80000000 FFFFFFFF bne_true
F 5 DEADBEEF DEADBEEF 00000000 bne_false
0 6 00000001 00000002 00000000 nop_single
1 1 00000001 00000001 00000002 seq_add
0 2 00000000 00000000 00000000 seq_nop
2 3 00000009 00000002 00000007 seq_sub
C 4 00000002 00000001 FFFFFFFF seq_bgt
7 5 0000FFFF 000000FF 000000FF seq_land
A 6 0000000F 00000000 00000004 seq_popcnt
3 7 00000003 00000003 00000009 seq_mul

// File: sim/exec_tb.sv
// --------------------
// Testbench for the execution stage.
// Reads instruction vectors from the stim file, issues them
// with random idle gaps and checks every writeback slot
// against the expected record and its fixed latency.
// --------------------

`timescale 1ns/1ps

module exec_tb import exec_pkg::*; ();

    localparam int LATENCY = 4;
    localparam int CLOCK_PERIOD = 100;
    localparam string STIM_FILE = "sim/exec_stim.txt";

    logic clock;
    logic rst_n;
    issue_t issue;
    wb_t wb;

    // Stimulus table as read from the file
    logic [3:0] st_op [$];
    reg_addr_t st_dest [$];
    data_t st_a [$];
    data_t st_b [$];
    data_t st_exp [$];
    string st_name [$];

    // Writeback slots still to be checked in arrival order
    string exp_name [$];
    reg_addr_t exp_dest [$];
    data_t exp_data [$];
    int exp_due [$];
    logic exp_none [$];

    int edge_count = 0;
    int pass_count;
    int error_count;
    logic stim_loaded = 1'b0;
    logic [15:0] lfsr_state;

    exec_clock_gen i_clock_gen (
        .clock(clock),
        .rst_n(rst_n)
    );

    exec_core i_dut (
        .clock(clock),
        .rst_n(rst_n),
        .issue(issue),
        .wb(wb)
    );

    // Fibonacci LFSR with taps at 16, 14, 13 and 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] state);
        logic feedback;
        feedback = state[15] ^ state[13] ^ state[12] ^ state[10];
        return {state[14:0], feedback};
    endfunction

    function automatic int idle_gap();
        int gap;
        gap = 0;
        for (int i = 0; i < 2; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            gap = (gap << 1) | int'(lfsr_state[0]);
        end
        return gap;
    endfunction

    task automatic load_stimulus();
        int fd;
        int fields;
        string line;
        string name;
        logic [31:0] op;
        logic [31:0] dest;
        data_t a;
        data_t b;
        data_t expected;
        fd = $fopen(STIM_FILE, "r");
        if (fd != 0) begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() > 0 && line.getc(0) != "#") begin
                    fields = $sscanf(line, "%h %h %h %h %h %s",
                                     op, dest, a, b, expected, name);
                    if (fields == 6) begin
                        st_op.push_back(op[3:0]);
                        st_dest.push_back(dest[3:0]);
                        st_a.push_back(a);
                        st_b.push_back(b);
                        st_exp.push_back(expected);
                        st_name.push_back(name);
                    end else if (fields > 0) begin
                        $display("Stimulus line could not be parsed: %s", line);
                        error_count++;
                    end
                end
            end
            $fclose(fd);
            stim_loaded = 1'b1;
        end
    endtask

    task automatic drive_idle();
        issue = '0;
    endtask

    // Every issued line books the slot where its record must appear
    task automatic issue_line(input int idx);
        issue.valid = 1'b1;
        issue.opcode = opcode_t'(st_op[idx]);
        issue.dest = st_dest[idx];
        issue.operand_a = st_a[idx];
        issue.operand_b = st_b[idx];
        exp_name.push_back(st_name[idx]);
        exp_dest.push_back(st_dest[idx]);
        exp_data.push_back(st_exp[idx]);
        exp_due.push_back(edge_count + LATENCY);
        exp_none.push_back(opcode_t'(st_op[idx]) == NOP);
    endtask

    task automatic check_record();
        string name;
        reg_addr_t dest;
        data_t data;
        logic none;
        int errors_before;
        name = exp_name.pop_front();
        dest = exp_dest.pop_front();
        data = exp_data.pop_front();
        none = exp_none.pop_front();
        void'(exp_due.pop_front());
        errors_before = error_count;
        if (none) begin
            if (wb.valid !== 1'b0) begin
                $display("NOP test %s produced a writeback record", name);
                error_count++;
            end
        end else if (wb.valid !== 1'b1) begin
            $display("Missing writeback record for test %s at edge %0d", name, edge_count);
            error_count++;
        end else begin
            if (wb.dest !== dest) begin
                $display("Mismatch in test %s dest: expected %h, actual %h",
                         name, dest, wb.dest);
                error_count++;
            end
            if (wb.data !== data) begin
                $display("Mismatch in test %s data: expected %h, actual %h",
                         name, data, wb.data);
                error_count++;
            end
        end
        if (error_count == errors_before) begin
            $display("PASS %s", name);
            pass_count++;
        end
    endtask

    task automatic close_run();
        $display("Tests passed: %0d, errors: %0d", pass_count, error_count);
        if (error_count == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    endtask

    task automatic run_tests();
        int gap;
        while (rst_n !== 1'b1) begin
            @(posedge clock);
        end
        repeat (3) begin
            @(posedge clock);
        end
        if (error_count == 0) begin
            $display("PASS reset_state");
            pass_count++;
        end else begin
            $display("Test reset_state failed with %0d errors", error_count);
        end
        for (int i = 0; i < st_name.size(); i++) begin
            @(posedge clock);
            #1;
            issue_line(i);
            // Lines named seq_ go out back to back to fill the pipeline
            if (st_name[i].substr(0, 3) != "seq_") begin
                gap = idle_gap();
                repeat (gap) begin
                    @(posedge clock);
                    #1;
                    drive_idle();
                end
            end
        end
        @(posedge clock);
        #1;
        drive_idle();
        while (exp_name.size() != 0) begin
            @(posedge clock);
        end
        repeat (LATENCY) begin
            @(posedge clock);
        end
    endtask

    initial begin
        forever begin
            @(posedge clock);
            edge_count = edge_count + 1;
        end
    end

    // Writeback slots are checked on the falling edge
    initial begin
        forever begin
            @(negedge clock);
            if (rst_n !== 1'b1) begin
                if (wb !== '0) begin
                    $display("Writeback output not cleared while reset is asserted");
                    error_count++;
                end
            end else if (exp_due.size() > 0 && exp_due[0] == edge_count) begin
                check_record();
            end else if (wb.valid !== 1'b0) begin
                $display("Unexpected writeback record at edge %0d: dest %h data %h",
                         edge_count, wb.dest, wb.data);
                error_count++;
            end
        end
    end

    initial begin
        longint limit_ns;
        wait (stim_loaded === 1'b1);
        limit_ns = (longint'(st_name.size()) * 5 + 20) * longint'(CLOCK_PERIOD);
        #(limit_ns);
        $display("Timeout after %0d ns with %0d writeback records still missing",
                 limit_ns, exp_name.size());
        error_count++;
        close_run();
    end

    initial begin
        issue = '0;
        pass_count = 0;
        error_count = 0;
        lfsr_state = 16'd58963;
        load_stimulus();
        if (stim_loaded !== 1'b1) begin
            $display("Could not read stimulus file %s", STIM_FILE);
            error_count++;
            close_run();
        end else begin
            run_tests();
            close_run();
        end
    end

endmodule
